// File: common/coh_consts.svh
/*
 * shared constants of the cache-side coherence endpoint
 * address and line geometry, way select and metadata widths
 * queue depth, NoC message codes, cache bus codes
 * coherence state encodings
 */
`ifndef COH_CONSTS_SVH
`define COH_CONSTS_SVH

// geometry, tag sits above index and word offset
`define COH_ADDR_BITS   32
`define COH_OFFSET_BITS 2
`define COH_INDEX_BITS  8
`define COH_TAG_BITS    22
`define COH_LINE_BITS   128
`define COH_WAY_BITS    2
`define COH_MSG_BITS    4
`define COH_QUEUE_DEPTH 4
// status bits (valid, dirty, spare) then 2-bit coherence state
`define COH_META_BITS   5

// NoC message codes
`define NOC_NOMSG    4'd0
`define NOC_GETS     4'd1
`define NOC_GETM     4'd2
`define NOC_PUTS     4'd3
`define NOC_PUTM     4'd4
`define NOC_PUTE     4'd5
`define NOC_RESPPUTM 4'd6
`define NOC_INVACK   4'd7
`define NOC_NACKD    4'd8
`define NOC_FWDGETS  4'd9
`define NOC_INV      4'd10
`define NOC_DATA     4'd11
`define NOC_PUTACK   4'd12
`define NOC_NACKB    4'd13

// cache bus codes
`define BUS_NO_REQ    4'd0
`define BUS_R_REQ     4'd1
`define BUS_WB_REQ    4'd2
`define BUS_FLUSH_S   4'd4
`define BUS_RFO_BCAST 4'd5
`define BUS_WS_BCAST  4'd6
`define BUS_MEM_RESP  4'd7
`define BUS_EN_ACCESS 4'd8

// coherence states
`define COH_INVALID 2'd0
`define COH_SHARED  2'd1

`endif

// File: common/coh_pkg.sv
/*
 * packed types of the coherence endpoint
 *   noc_msg_t      message on the network side
 *   cache_req_t    request or response on the cache controller side
 *   mem_port_req_t maintenance port command to the cache memory
 *   mem_port_rsp_t maintenance port read result
 */
`include "coh_consts.svh"

package coh_pkg;

  // code, address, line; 164 bits in all
  typedef struct packed {
    logic [`COH_MSG_BITS-1:0]  msg;
    logic [`COH_ADDR_BITS-1:0] addr;
    logic [`COH_LINE_BITS-1:0] data;
  } noc_msg_t;

  // msg carries a cache bus code here
  typedef struct packed {
    logic [`COH_MSG_BITS-1:0]  msg;
    logic [`COH_ADDR_BITS-1:0] addr;
    logic [`COH_LINE_BITS-1:0] data;
  } cache_req_t;

  typedef struct packed {
    logic                       read;
    logic                       write;
    logic                       invalidate;
    logic [`COH_INDEX_BITS-1:0] index;
    logic [`COH_TAG_BITS-1:0]   tag;
    logic [`COH_META_BITS-1:0]  metadata;
    logic [`COH_LINE_BITS-1:0]  write_data;
    logic [`COH_WAY_BITS-1:0]   way;
  } mem_port_req_t;

  // valid the cycle after a read
  typedef struct packed {
    logic [`COH_LINE_BITS-1:0] read_data;
    logic [`COH_WAY_BITS-1:0]  way;
    logic                      hit;
    logic                      dirty;
  } mem_port_rsp_t;

endpackage

// File: hdl/coherence_engine.sv
/*
 * coherence FSM of the endpoint
 * serves directory responses, then directory requests, then the cache
 * bus to NoC code translation and back, NackB retry of the held request
 * FwdGetS / Inv handling through the cache maintenance port
 */
`timescale 1ns/1ps
`include "coh_consts.svh"

module coherence_engine
  import coh_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  cache_req_t    cache_req_in,
  output cache_req_t    cache_rsp_out,
  output logic          busy,
  input  noc_msg_t      req_head,
  input  noc_msg_t      rsp_head,
  input  logic          req_empty,
  input  logic          rsp_empty,
  output logic          req_pop,
  output logic          rsp_pop,
  input  logic          packetizer_busy,
  output noc_msg_t      noc_out,
  output mem_port_req_t mem_req,
  input  mem_port_rsp_t mem_rsp
);
  typedef enum logic [2:0] {
    idle, dir_resp, mem_read, dir_req, cache_req, noc_send
  } state_t;

  state_t                     state;
  // blocking controller has a request outstanding
  logic                       inservice;
  noc_msg_t                   cur;
  logic                       cache_take;
  logic                       mem_write;
  logic                       mem_inv;
  logic [`COH_META_BITS-1:0]  mem_meta;
  logic [`COH_LINE_BITS-1:0]  mem_wdata;
  logic [`COH_WAY_BITS-1:0]   mem_way;

  function automatic logic [`COH_MSG_BITS-1:0] to_noc(input logic [`COH_MSG_BITS-1:0] code);
    case (code)
      `BUS_R_REQ:     return `NOC_GETS;
      `BUS_WB_REQ:    return `NOC_PUTM;
      `BUS_FLUSH_S:   return `NOC_PUTS;
      `BUS_RFO_BCAST: return `NOC_GETM;
      `BUS_WS_BCAST:  return `NOC_GETM;
      default:        return `NOC_NOMSG;
    endcase
  endfunction

  // ws_held: controller still holds a WS_BCAST
  function automatic logic [`COH_MSG_BITS-1:0] to_cache(input logic [`COH_MSG_BITS-1:0] code,
                                                         input logic ws_held);
    case (code)
      `NOC_PUTACK: return `BUS_MEM_RESP;
      `NOC_DATA:   return ws_held ? `BUS_EN_ACCESS : code;
      `NOC_NACKB:  return `BUS_NO_REQ;
      default:     return code;
    endcase
  endfunction

  // only codes with a NoC meaning start a transaction
  assign cache_take = !inservice && (to_noc(cache_req_in.msg) != `NOC_NOMSG);

  // pop as the head is latched in idle, responses first
  assign rsp_pop = (state == idle) && !rsp_empty;
  assign req_pop = (state == idle) && rsp_empty && !req_empty;
  assign busy    = !((state == idle) && req_empty && rsp_empty);

  always_comb begin
    // read is high for the single mem_read cycle
    mem_req.read       = (state == mem_read);
    mem_req.write      = mem_write;
    mem_req.invalidate = mem_inv;
    mem_req.index      = cur.addr[`COH_OFFSET_BITS +: `COH_INDEX_BITS];
    mem_req.tag        = cur.addr[`COH_ADDR_BITS-1 -: `COH_TAG_BITS];
    mem_req.metadata   = mem_meta;
    mem_req.write_data = mem_wdata;
    mem_req.way        = mem_way;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state             <= idle;
      inservice         <= 1'b0;
      noc_out.msg       <= `NOC_NOMSG;
      cache_rsp_out.msg <= `BUS_NO_REQ;
      mem_write         <= 1'b0;
      mem_inv           <= 1'b0;
    end else begin
      // strobes and the cache response last one cycle
      cache_rsp_out.msg <= `BUS_NO_REQ;
      mem_write         <= 1'b0;
      mem_inv           <= 1'b0;
      case (state)
        idle: begin
          if (!rsp_empty) begin
            cur   <= rsp_head;
            state <= dir_resp;
          end else if (!req_empty) begin
            cur   <= req_head;
            state <= mem_read;
          end else if (cache_take) begin
            cur       <= cache_req_in;
            inservice <= 1'b1;
            state     <= cache_req;
          end
        end
        dir_resp: begin
          if (cur.msg == `NOC_NACKB && inservice) begin
            // directory refused, controller still holds the request
            cur.msg  <= to_noc(cache_req_in.msg);
            cur.addr <= cache_req_in.addr;
            cur.data <= cache_req_in.data;
            state    <= noc_send;
          end else begin
            cache_rsp_out.msg  <= to_cache(cur.msg, cache_req_in.msg == `BUS_WS_BCAST);
            cache_rsp_out.addr <= cur.addr;
            cache_rsp_out.data <= cur.data;
            inservice          <= 1'b0;
            state              <= idle;
          end
        end
        mem_read: begin
          // maintenance port answers during dir_req
          state <= dir_req;
        end
        dir_req: begin
          noc_out.addr <= cur.addr;
          mem_way      <= mem_rsp.way;
          if (!mem_rsp.hit) begin
            noc_out.msg  <= `NOC_NACKD;
            noc_out.data <= '0;
          end else if (cur.msg == `NOC_FWDGETS) begin
            // keep the line, drop to shared
            mem_write    <= 1'b1;
            mem_meta     <= {3'b100, `COH_SHARED};
            mem_wdata    <= mem_rsp.read_data;
            noc_out.msg  <= mem_rsp.dirty ? `NOC_RESPPUTM : `NOC_PUTE;
            noc_out.data <= mem_rsp.read_data;
          end else begin
            // Inv, dirty data goes back with the ack
            mem_inv      <= 1'b1;
            mem_meta     <= {3'b000, `COH_INVALID};
            mem_wdata    <= '0;
            noc_out.msg  <= mem_rsp.dirty ? `NOC_RESPPUTM : `NOC_INVACK;
            noc_out.data <= mem_rsp.read_data;
          end
          state <= noc_send;
        end
        cache_req: begin
          cur.msg <= to_noc(cur.msg);
          state   <= noc_send;
        end
        noc_send: begin
          if (noc_out.msg == `NOC_NOMSG) begin
            // load the held message unless dir_req already did
            noc_out <= cur;
          end else if (!packetizer_busy) begin
            noc_out.msg <= `NOC_NOMSG;
            state       <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// File: hdl/msg_queue.sv
/*
 * synchronous FIFO for any payload type
 * circular buffer, read/write pointers and occupancy count
 * head is shown combinationally, pop takes it at the next edge
 */
`timescale 1ns/1ps

module msg_queue #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     full
);
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t            store [DEPTH];
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS:0]   count;
  logic                do_push;
  logic                do_pop;

  // pointer advance with wrap, DEPTH need not be a power of two
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
    return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == (PTR_BITS + 1)'(DEPTH));
  // a push into a full queue is lost, pop on empty does nothing
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = store[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      // simultaneous push and pop leaves the count alone
      count <= count + (PTR_BITS + 1)'(do_push) - (PTR_BITS + 1)'(do_pop);
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) store[wr_ptr] <= push_data;
  end

endmodule

// File: hdl/noc_cache_interface.sv
/*
 * top level of the cache-side coherence endpoint
 * message handler on the NoC receive side
 * coherence engine toward the cache and the NoC send side
 */
`timescale 1ns/1ps

module noc_cache_interface
  import coh_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  noc_msg_t      noc_in,
  output logic          interface_busy,
  output noc_msg_t      noc_out,
  input  logic          packetizer_busy,
  input  cache_req_t    cache_req_in,
  output cache_req_t    cache_rsp_out,
  output logic          busy,
  output mem_port_req_t mem_req,
  input  mem_port_rsp_t mem_rsp
);
  noc_msg_t req_head;
  noc_msg_t rsp_head;
  logic     req_empty;
  logic     rsp_empty;
  logic     req_pop;
  logic     rsp_pop;

  message_handler u_message_handler (
    .clock         (clock),
    .reset         (reset),
    .noc_in        (noc_in),
    .interface_busy(interface_busy),
    .req_pop       (req_pop),
    .rsp_pop       (rsp_pop),
    .req_head      (req_head),
    .rsp_head      (rsp_head),
    .req_empty     (req_empty),
    .rsp_empty     (rsp_empty)
  );

  coherence_engine u_coherence_engine (
    .clock          (clock),
    .reset          (reset),
    .cache_req_in   (cache_req_in),
    .cache_rsp_out  (cache_rsp_out),
    .busy           (busy),
    .req_head       (req_head),
    .rsp_head       (rsp_head),
    .req_empty      (req_empty),
    .rsp_empty      (rsp_empty),
    .req_pop        (req_pop),
    .rsp_pop        (rsp_pop),
    .packetizer_busy(packetizer_busy),
    .noc_out        (noc_out),
    .mem_req        (mem_req),
    .mem_rsp        (mem_rsp)
  );

endmodule

// File: message_handler/message_handler.sv
/*
 * NoC receive side of the endpoint
 * sorts incoming messages into a directory-request queue
 * and a directory-response queue
 * back-pressure to the network when either queue is full
 */
`timescale 1ns/1ps
`include "coh_consts.svh"

module message_handler
  import coh_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  noc_msg_t noc_in,
  output logic     interface_busy,
  input  logic     req_pop,
  input  logic     rsp_pop,
  output noc_msg_t req_head,
  output noc_msg_t rsp_head,
  output logic     req_empty,
  output logic     rsp_empty
);
  logic present;
  logic is_dir_req;
  logic accept;
  logic req_full;
  logic rsp_full;

  // a message is there whenever its code is not NoMsg
  assign present    = (noc_in.msg != `NOC_NOMSG);
  // only FwdGetS and Inv are requests from the directory
  assign is_dir_req = (noc_in.msg == `NOC_FWDGETS) || (noc_in.msg == `NOC_INV);
  // network must hold off while busy, anything sent then is dropped
  assign accept     = present && !interface_busy;

  assign interface_busy = req_full || rsp_full;

  // directory requests
  msg_queue #(
    .payload_t(noc_msg_t),
    .DEPTH    (`COH_QUEUE_DEPTH)
  ) u_req_queue (
    .clock    (clock),
    .reset    (reset),
    .push     (accept && is_dir_req),
    .push_data(noc_in),
    .pop      (req_pop),
    .head     (req_head),
    .empty    (req_empty),
    .full     (req_full)
  );

  // responses, NackB included
  msg_queue #(
    .payload_t(noc_msg_t),
    .DEPTH    (`COH_QUEUE_DEPTH)
  ) u_rsp_queue (
    .clock    (clock),
    .reset    (reset),
    .push     (accept && !is_dir_req),
    .push_data(noc_in),
    .pop      (rsp_pop),
    .head     (rsp_head),
    .empty    (rsp_empty),
    .full     (rsp_full)
  );

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_noc_cache_interface -f verilog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_noc_cache_interface)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// File: sim/clock_gen.sv
/*
 * testbench clock and reset source
 *   8 ns clock period
 *   synchronous reset held high for the first 2 rising edges
 */
`timescale 1ns/1ps

module clock_gen #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic clock,
  output logic reset
);

  initial clock = 1'b0;

  always #(HALF_PERIOD) clock = ~clock;

  // release on a falling edge, clear of the sampling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

// File: sim/tb_noc_cache_interface.sv
/*
 * directed testbench of the cache-side coherence endpoint
 *   cache memory model on the maintenance port
 *   LFSR source for addresses, lines and way numbers
 *   tests: reset values, cache requests, directory responses,
 *   NackB retry, FwdGetS and Inv requests
 *   cycle limit on the whole run
 */
`timescale 1ns/1ps
`include "coh_consts.svh"

module tb_noc_cache_interface
  import coh_pkg::*;
();
  // all six tests take about 150 cycles and the limit leaves ample margin
  localparam int CYCLE_LIMIT = 400;

  logic          clock;
  logic          reset;
  noc_msg_t      noc_in;
  logic          interface_busy;
  noc_msg_t      noc_out;
  logic          packetizer_busy;
  cache_req_t    cache_req_in;
  cache_req_t    cache_rsp_out;
  logic          busy;
  mem_port_req_t mem_req;
  mem_port_rsp_t mem_rsp = '0;

  // memory model knobs that the tests set
  logic                        model_hit;
  logic                        model_dirty;
  logic [`COH_WAY_BITS-1:0]    model_way;
  logic [`COH_LINE_BITS-1:0]   model_line;
  logic                        read_pending = 1'b0;
  // what the model saw on the maintenance port
  int                          read_count = 0;
  int                          write_count = 0;
  int                          inv_count = 0;
  logic [`COH_INDEX_BITS-1:0]  last_index;
  logic [`COH_TAG_BITS-1:0]    last_tag;
  logic [`COH_META_BITS-1:0]   last_meta;
  logic [`COH_WAY_BITS-1:0]    last_way;
  logic [`COH_LINE_BITS-1:0]   last_wdata;

  logic [15:0] lfsr_state = 16'd9782;
  int          cycle_count = 0;
  int          error_count = 0;
  int          errors_at_start;
  int          tests_passed = 0;
  int          tests_failed = 0;
  string       current_test;

  clock_gen u_clock_gen (
    .clock(clock),
    .reset(reset)
  );

  noc_cache_interface u_noc_cache_interface (
    .clock          (clock),
    .reset          (reset),
    .noc_in         (noc_in),
    .interface_busy (interface_busy),
    .noc_out        (noc_out),
    .packetizer_busy(packetizer_busy),
    .cache_req_in   (cache_req_in),
    .cache_rsp_out  (cache_rsp_out),
    .busy           (busy),
    .mem_req        (mem_req),
    .mem_rsp        (mem_rsp)
  );

  // cache memory answers a read in the following cycle and holds it until the next read
  always @(negedge clock) begin
    if (read_pending) begin
      mem_rsp = '{read_data: model_line, way: model_way, hit: model_hit,
                 dirty: model_dirty};
    end
    read_pending = mem_req.read;
    if (mem_req.read) begin
      read_count = read_count + 1;
      last_index = mem_req.index;
      last_tag   = mem_req.tag;
    end
    if (mem_req.write || mem_req.invalidate) begin
      write_count = write_count + int'(mem_req.write);
      inv_count   = inv_count + int'(mem_req.invalidate);
      last_meta   = mem_req.metadata;
      last_way    = mem_req.way;
      last_wdata  = mem_req.write_data;
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic logic [`COH_LINE_BITS-1:0] random_line();
    return {random_bits(32), random_bits(32), random_bits(32), random_bits(32)};
  endfunction

  function automatic noc_msg_t make_msg(input logic [`COH_MSG_BITS-1:0] code,
                                        input logic [`COH_ADDR_BITS-1:0] addr,
                                        input logic [`COH_LINE_BITS-1:0] data);
    noc_msg_t m;
    m.msg  = code;
    m.addr = addr;
    m.data = data;
    return m;
  endfunction

  task automatic expect_eq(input string name, input logic [163:0] got,
                           input logic [163:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      error_count = error_count + 1;
    end
  endtask

  task automatic start_test(input string name);
    current_test    = name;
    errors_at_start = error_count;
  endtask

  task automatic finish_test();
    if (error_count == errors_at_start) begin
      tests_passed = tests_passed + 1;
      $display("test %s: ok", current_test);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %s: %0d checks failed", current_test, error_count - errors_at_start);
    end
  endtask

  // one message from the network is pushed at the next rising edge
  task automatic send_noc(input noc_msg_t msg);
    @(negedge clock);
    expect_eq("interface_busy", 164'(interface_busy), 164'(1'b0));
    noc_in = msg;
    @(negedge clock);
    noc_in.msg = `NOC_NOMSG;
  endtask

  // noc_out is valid after delay edges and held while the packetizer stalls
  task automatic expect_noc_out(input noc_msg_t exp, input int delay, input int hold);
    for (int i = 1; i < delay; i++) begin
      @(negedge clock);
      expect_eq("noc_out.msg", 164'(noc_out.msg), 164'(`NOC_NOMSG));
      expect_eq("cache_rsp_out.msg", 164'(cache_rsp_out.msg), 164'(`BUS_NO_REQ));
    end
    @(negedge clock);
    expect_eq("noc_out", noc_out, exp);
    packetizer_busy = (hold > 0);
    for (int i = 0; i < hold; i++) begin
      @(negedge clock);
      expect_eq("noc_out", noc_out, exp);
      expect_eq("busy", 164'(busy), 164'(1'b1));
    end
    packetizer_busy = 1'b0;
    @(negedge clock);
    expect_eq("noc_out.msg", 164'(noc_out.msg), 164'(`NOC_NOMSG));
    expect_eq("busy", 164'(busy), 164'(1'b0));
  endtask

  // response shows on cache_rsp_out for one cycle two edges after the push
  task automatic expect_cache_rsp(input noc_msg_t exp);
    @(negedge clock);
    expect_eq("cache_rsp_out.msg", 164'(cache_rsp_out.msg), 164'(`BUS_NO_REQ));
    @(negedge clock);
    expect_eq("cache_rsp_out", cache_rsp_out, exp);
    // controller drops its request once answered
    cache_req_in.msg = `BUS_NO_REQ;
    @(negedge clock);
    expect_eq("cache_rsp_out.msg", 164'(cache_rsp_out.msg), 164'(`BUS_NO_REQ));
  endtask

  task automatic issue_request(input logic [`COH_MSG_BITS-1:0] bus_code,
                               input logic [`COH_MSG_BITS-1:0] exp_noc,
                               input int hold, output noc_msg_t req);
    req = make_msg(bus_code, random_bits(32), random_line());
    @(negedge clock);
    cache_req_in.msg  = bus_code;
    cache_req_in.addr = req.addr;
    cache_req_in.data = req.data;
    @(negedge clock);
    expect_eq("busy", 164'(busy), 164'(1'b1));
    expect_noc_out(make_msg(exp_noc, req.addr, req.data), 2, hold);
  endtask

  task automatic answer_request(input logic [`COH_MSG_BITS-1:0] rsp_code,
                                input logic [`COH_MSG_BITS-1:0] cache_code,
                                input logic [`COH_ADDR_BITS-1:0] addr);
    logic [`COH_LINE_BITS-1:0] line;
    line = random_line();
    send_noc(make_msg(rsp_code, addr, line));
    expect_cache_rsp(make_msg(cache_code, addr, line));
  endtask

  task automatic dir_request(input logic [`COH_MSG_BITS-1:0] code, input logic hit,
                             input logic dirty, input logic [`COH_MSG_BITS-1:0] exp_code,
                             input logic exp_write, input logic exp_inv);
    noc_msg_t req;
    int       reads0;
    int       writes0;
    int       invs0;
    req         = make_msg(code, random_bits(32), random_line());
    model_hit   = hit;
    model_dirty = dirty;
    model_way   = 2'(random_bits(2));
    model_line  = random_line();
    reads0      = read_count;
    writes0     = write_count;
    invs0       = inv_count;
    send_noc(req);
    // miss answers with zero data
    expect_noc_out(make_msg(exp_code, req.addr, hit ? model_line : '0), 3, 0);
    expect_eq("mem_req.read count", 164'(read_count - reads0), 164'(1));
    expect_eq("mem_req.write count", 164'(write_count - writes0), 164'(exp_write));
    expect_eq("mem_req.invalidate count", 164'(inv_count - invs0), 164'(exp_inv));
    // index sits above the two offset bits and the tag fills the top 22
    expect_eq("mem_req.index", 164'(last_index), 164'(req.addr[9:2]));
    expect_eq("mem_req.tag", 164'(last_tag), 164'(req.addr[31:10]));
    if (exp_write) begin
      // valid set, dirty and spare clear, shared state
      expect_eq("mem_req.metadata", 164'(last_meta), 164'(5'b10001));
      expect_eq("mem_req.way", 164'(last_way), 164'(model_way));
      expect_eq("mem_req.write_data", 164'(last_wdata), 164'(model_line));
    end
    if (exp_inv) begin
      expect_eq("mem_req.metadata", 164'(last_meta), 164'(5'd0));
      expect_eq("mem_req.way", 164'(last_way), 164'(model_way));
    end
  endtask

  task automatic reset_values();
    start_test("after reset");
    @(negedge clock);
    expect_eq("noc_out.msg", 164'(noc_out.msg), 164'(`NOC_NOMSG));
    expect_eq("cache_rsp_out.msg", 164'(cache_rsp_out.msg), 164'(`BUS_NO_REQ));
    expect_eq("mem_req.read", 164'(mem_req.read), 164'(1'b0));
    expect_eq("mem_req.write", 164'(mem_req.write), 164'(1'b0));
    expect_eq("mem_req.invalidate", 164'(mem_req.invalidate), 164'(1'b0));
    expect_eq("busy", 164'(busy), 164'(1'b0));
    expect_eq("interface_busy", 164'(interface_busy), 164'(1'b0));
    finish_test();
  endtask

  task automatic cache_requests();
    noc_msg_t req;
    start_test("cache requests");
    issue_request(`BUS_R_REQ, `NOC_GETS, 0, req);
    answer_request(`NOC_DATA, `NOC_DATA, req.addr);
    issue_request(`BUS_WB_REQ, `NOC_PUTM, 0, req);
    answer_request(`NOC_PUTACK, `BUS_MEM_RESP, req.addr);
    issue_request(`BUS_FLUSH_S, `NOC_PUTS, 0, req);
    answer_request(`NOC_PUTACK, `BUS_MEM_RESP, req.addr);
    // network stalls the send for 5 cycles
    issue_request(`BUS_RFO_BCAST, `NOC_GETM, 5, req);
    answer_request(`NOC_DATA, `NOC_DATA, req.addr);
    finish_test();
  endtask

  task automatic dir_responses();
    noc_msg_t req;
    start_test("directory responses");
    issue_request(`BUS_WS_BCAST, `NOC_GETM, 0, req);
    answer_request(`NOC_DATA, `BUS_EN_ACCESS, req.addr);
    // nothing held by the controller here
    answer_request(`NOC_DATA, `NOC_DATA, random_bits(32));
    answer_request(`NOC_PUTACK, `BUS_MEM_RESP, random_bits(32));
    finish_test();
  endtask

  task automatic nackb_retry();
    noc_msg_t req;
    start_test("nackb retry");
    issue_request(`BUS_R_REQ, `NOC_GETS, 0, req);
    send_noc(make_msg(`NOC_NACKB, req.addr, '0));
    // reissue instead of a cache response
    expect_noc_out(make_msg(`NOC_GETS, req.addr, req.data), 3, 0);
    answer_request(`NOC_DATA, `NOC_DATA, req.addr);
    finish_test();
  endtask

  task automatic fwd_gets_requests();
    start_test("fwdgets");
    dir_request(`NOC_FWDGETS, 1'b1, 1'b1, `NOC_RESPPUTM, 1'b1, 1'b0);
    dir_request(`NOC_FWDGETS, 1'b1, 1'b0, `NOC_PUTE, 1'b1, 1'b0);
    dir_request(`NOC_FWDGETS, 1'b0, 1'b0, `NOC_NACKD, 1'b0, 1'b0);
    finish_test();
  endtask

  task automatic inv_requests();
    start_test("inv");
    dir_request(`NOC_INV, 1'b1, 1'b0, `NOC_INVACK, 1'b0, 1'b1);
    dir_request(`NOC_INV, 1'b1, 1'b1, `NOC_RESPPUTM, 1'b0, 1'b1);
    finish_test();
  endtask

  initial begin
    noc_in          = '0;
    cache_req_in    = '0;
    packetizer_busy = 1'b0;
    model_hit       = 1'b0;
    model_dirty     = 1'b0;
    model_way       = '0;
    model_line      = '0;
    @(negedge reset);
    reset_values();
    cache_requests();
    dir_responses();
    nackb_retry();
    fwd_gets_requests();
    inv_requests();
    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+common
common/coh_pkg.sv
hdl/msg_queue.sv
message_handler/message_handler.sv
hdl/coherence_engine.sv
hdl/noc_cache_interface.sv
sim/clock_gen.sv
sim/tb_noc_cache_interface.sv
